// ==== hw/mips_pkg.sv ====
package mips_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [5:0]  funct_t;

  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_and  = 4'd2,
    alu_or   = 4'd3,
    alu_xor  = 4'd4,
    alu_slt  = 4'd5,
    alu_sltu = 4'd6,
    alu_sll  = 4'd7,
    alu_srl  = 4'd8,
    alu_lui  = 4'd9
  } alu_op_t;

  // decoded controls for one instruction
  typedef struct packed {
    alu_op_t alu_op;
    logic    alu_src_imm;
    logic    imm_zero_ext;
    logic    reg_dst_rd;
    logic    link;
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    mem_to_reg;
    logic    branch_eq;
    logic    branch_ne;
    logic    jump_imm;
    logic    jump_reg;
  } ctrl_t;

  typedef enum logic [0:0] {
    EXEC   = 1'b0,
    HALTED = 1'b1
  } cpu_state_t;

  localparam word_t reset_vector = 32'hBFC0_0000;

  // primary opcodes
  localparam opcode_t op_special = 6'h00;
  localparam opcode_t op_j       = 6'h02;
  localparam opcode_t op_jal     = 6'h03;
  localparam opcode_t op_beq     = 6'h04;
  localparam opcode_t op_bne     = 6'h05;
  localparam opcode_t op_addiu   = 6'h09;
  localparam opcode_t op_slti    = 6'h0a;
  localparam opcode_t op_andi    = 6'h0c;
  localparam opcode_t op_ori     = 6'h0d;
  localparam opcode_t op_xori    = 6'h0e;
  localparam opcode_t op_lui     = 6'h0f;
  localparam opcode_t op_lw      = 6'h23;
  localparam opcode_t op_sw      = 6'h2b;

  // function codes under op_special
  localparam funct_t fn_sll  = 6'h00;
  localparam funct_t fn_srl  = 6'h02;
  localparam funct_t fn_jr   = 6'h08;
  localparam funct_t fn_jalr = 6'h09;
  localparam funct_t fn_addu = 6'h21;
  localparam funct_t fn_subu = 6'h23;
  localparam funct_t fn_and  = 6'h24;
  localparam funct_t fn_or   = 6'h25;
  localparam funct_t fn_xor  = 6'h26;
  localparam funct_t fn_slt  = 6'h2a;
  localparam funct_t fn_sltu = 6'h2b;

  localparam reg_addr_t reg_v0 = 5'd2;
  localparam reg_addr_t reg_ra = 5'd31;

endpackage

// ==== hw/control.sv ====
`timescale 1ns/1ps

module control (
  input  mips_pkg::opcode_t opcode,
  input  mips_pkg::funct_t  funct,
  output mips_pkg::ctrl_t   ctrl
);
  import mips_pkg::*;

  always_comb begin
    // anything not listed below falls through as a no-op
    ctrl = '0;
    ctrl.alu_op = alu_add;
    case (opcode)
      op_special: begin
        ctrl.reg_dst_rd = 1'b1;
        case (funct)
          fn_sll: begin
            ctrl.alu_op = alu_sll;
            ctrl.reg_write = 1'b1;
          end
          fn_srl: begin
            ctrl.alu_op = alu_srl;
            ctrl.reg_write = 1'b1;
          end
          fn_jr: ctrl.jump_reg = 1'b1;
          fn_jalr: begin
            ctrl.jump_reg = 1'b1;
            ctrl.link = 1'b1;
            ctrl.reg_write = 1'b1;
          end
          fn_addu: ctrl.reg_write = 1'b1;
          fn_subu: begin
            ctrl.alu_op = alu_sub;
            ctrl.reg_write = 1'b1;
          end
          fn_and: begin
            ctrl.alu_op = alu_and;
            ctrl.reg_write = 1'b1;
          end
          fn_or: begin
            ctrl.alu_op = alu_or;
            ctrl.reg_write = 1'b1;
          end
          fn_xor: begin
            ctrl.alu_op = alu_xor;
            ctrl.reg_write = 1'b1;
          end
          fn_slt: begin
            ctrl.alu_op = alu_slt;
            ctrl.reg_write = 1'b1;
          end
          fn_sltu: begin
            ctrl.alu_op = alu_sltu;
            ctrl.reg_write = 1'b1;
          end
          default: ctrl.reg_dst_rd = 1'b0;
        endcase
      end
      op_j: ctrl.jump_imm = 1'b1;
      op_jal: begin
        // return address goes to ra
        ctrl.jump_imm = 1'b1;
        ctrl.link = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      // equality flag comes from comparing rs and rt in the alu
      op_beq: ctrl.branch_eq = 1'b1;
      op_bne: ctrl.branch_ne = 1'b1;
      op_addiu, op_slti, op_andi, op_ori, op_xori, op_lui: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write = 1'b1;
        case (opcode)
          op_slti: ctrl.alu_op = alu_slt;
          op_lui:  ctrl.alu_op = alu_lui;
          op_andi: ctrl.alu_op = alu_and;
          op_ori:  ctrl.alu_op = alu_or;
          op_xori: ctrl.alu_op = alu_xor;
          default: ctrl.alu_op = alu_add;
        endcase
        // logical forms take the immediate unsigned
        ctrl.imm_zero_ext = (opcode == op_andi) || (opcode == op_ori) || (opcode == op_xori);
      end
      op_lw: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.mem_read = 1'b1;
        ctrl.mem_to_reg = 1'b1;
      end
      op_sw: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_write = 1'b1;
      end
      default: ctrl.alu_op = alu_add;
    endcase
  end

endmodule

// ==== hw/register_file.sv ====
`timescale 1ns/1ps

module register_file (
  input  logic               clk,
  input  logic               reset,
  input  logic               clk_enable,
  input  mips_pkg::reg_addr_t rs,
  input  mips_pkg::reg_addr_t rt,
  input  mips_pkg::reg_addr_t rd,
  input  logic               write_enable,
  input  mips_pkg::word_t    write_data,
  output mips_pkg::word_t    rs_data,
  output mips_pkg::word_t    rt_data,
  output mips_pkg::word_t    register_v0
);
  import mips_pkg::*;

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (clk_enable && write_enable && (rd != '0)) begin
      // r0 never written so it stays zero
      regs[rd] <= write_data;
    end
  end

  // combinational reads
  assign rs_data = regs[rs];
  assign rt_data = regs[rt];

  assign register_v0 = regs[reg_v0];

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/1ps

module alu (
  input  mips_pkg::alu_op_t op,
  input  mips_pkg::word_t   a,
  input  mips_pkg::word_t   b,
  input  logic [4:0]        shamt,
  output mips_pkg::word_t   result,
  output logic              equal
);
  import mips_pkg::*;

  always_comb begin
    case (op)
      alu_add:  result = a + b;
      alu_sub:  result = a - b;
      alu_and:  result = a & b;
      alu_or:   result = a | b;
      alu_xor:  result = a ^ b;
      alu_slt:  result = {31'b0, $signed(a) < $signed(b)};
      alu_sltu: result = {31'b0, a < b};
      // shifts act on b only
      alu_sll:  result = b << shamt;
      alu_srl:  result = b >> shamt;
      alu_lui:  result = {b[15:0], 16'h0000};
      default:  result = '0;
    endcase
  end

  // raw operand compare for beq/bne
  assign equal = (a == b);

endmodule

// ==== hw/next_pc.sv ====
`timescale 1ns/1ps

module next_pc (
  input  logic            clk,
  input  logic            reset,
  input  logic            clk_enable,
  input  logic            advance,
  input  mips_pkg::ctrl_t ctrl,
  input  logic            equal,
  input  mips_pkg::word_t rs_data,
  input  mips_pkg::word_t imm_ext,
  input  logic [25:0]     jump_index,
  output mips_pkg::word_t pc,
  output mips_pkg::word_t pc_plus8
);
  import mips_pkg::*;

  word_t pc_plus4;
  word_t target;
  logic  taken;
  word_t pending_target;
  logic  pending_valid;

  assign pc_plus4 = pc + 32'd4;
  assign pc_plus8 = pc + 32'd8;

  assign taken = (ctrl.branch_eq && equal) || (ctrl.branch_ne && !equal) ||
                 ctrl.jump_imm || ctrl.jump_reg;

  always_comb begin
    if (ctrl.jump_reg) begin
      target = rs_data;
    end else if (ctrl.jump_imm) begin
      target = {pc_plus4[31:28], jump_index, 2'b00};
    end else begin
      target = pc_plus4 + {imm_ext[29:0], 2'b00};
    end
  end

  // target waits one instruction so the delay slot runs first
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= reset_vector;
      pending_valid <= 1'b0;
    end else if (clk_enable && advance) begin
      pc <= pending_valid ? pending_target : pc_plus4;
      pending_valid <= taken;
    end
  end

  always_ff @(posedge clk) begin
    if (clk_enable && advance) begin
      pending_target <= target;
    end
  end

endmodule

// ==== hw/mips_cpu_harvard.sv ====
`timescale 1ns/1ps

module mips_cpu_harvard (
  input  logic            clk,
  input  logic            reset,
  input  logic            clk_enable,
  output logic            active,
  output mips_pkg::word_t register_v0,
  output mips_pkg::word_t instr_address,
  input  mips_pkg::word_t instr_readdata,
  output mips_pkg::word_t data_address,
  output logic            data_write,
  output logic            data_read,
  output mips_pkg::word_t data_writedata,
  input  mips_pkg::word_t data_readdata
);
  import mips_pkg::*;

  cpu_state_t state;
  ctrl_t      ctrl;
  word_t      pc;
  word_t      pc_plus8;
  word_t      rs_data;
  word_t      rt_data;
  word_t      imm_sext;
  word_t      imm_ext;
  word_t      alu_b;
  word_t      alu_result;
  word_t      write_data;
  reg_addr_t  write_reg;
  logic       equal;
  logic       issue;

  // instruction at address zero is never executed
  assign issue = (state == EXEC) && (pc != '0) && !reset;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= EXEC;
    end else if (clk_enable && (state == EXEC) && (pc == '0)) begin
      state <= HALTED;
    end
  end

  assign active = (state == EXEC);

  control u_control (
    .opcode (instr_readdata[31:26]),
    .funct  (instr_readdata[5:0]),
    .ctrl   (ctrl)
  );

  assign imm_sext = {{16{instr_readdata[15]}}, instr_readdata[15:0]};
  assign imm_ext  = ctrl.imm_zero_ext ? {16'h0000, instr_readdata[15:0]} : imm_sext;
  assign alu_b    = ctrl.alu_src_imm ? imm_ext : rt_data;

  // jal links to ra, jalr to rd
  always_comb begin
    if (ctrl.link && !ctrl.reg_dst_rd) begin
      write_reg = reg_ra;
    end else if (ctrl.reg_dst_rd) begin
      write_reg = instr_readdata[15:11];
    end else begin
      write_reg = instr_readdata[20:16];
    end
  end

  always_comb begin
    if (ctrl.link) begin
      write_data = pc_plus8;
    end else if (ctrl.mem_to_reg) begin
      write_data = data_readdata;
    end else begin
      write_data = alu_result;
    end
  end

  register_file u_register_file (
    .clk          (clk),
    .reset        (reset),
    .clk_enable   (clk_enable),
    .rs           (instr_readdata[25:21]),
    .rt           (instr_readdata[20:16]),
    .rd           (write_reg),
    .write_enable (ctrl.reg_write && issue),
    .write_data   (write_data),
    .rs_data      (rs_data),
    .rt_data      (rt_data),
    .register_v0  (register_v0)
  );

  alu u_alu (
    .op     (ctrl.alu_op),
    .a      (rs_data),
    .b      (alu_b),
    .shamt  (instr_readdata[10:6]),
    .result (alu_result),
    .equal  (equal)
  );

  next_pc u_next_pc (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (clk_enable),
    .advance    (issue),
    .ctrl       (ctrl),
    .equal      (equal),
    .rs_data    (rs_data),
    .imm_ext    (imm_sext),
    .jump_index (instr_readdata[25:0]),
    .pc         (pc),
    .pc_plus8   (pc_plus8)
  );

  assign instr_address  = pc;
  assign data_address   = alu_result;
  assign data_writedata = rt_data;
  assign data_write     = ctrl.mem_write && issue;
  assign data_read      = ctrl.mem_read && issue;

endmodule

// ==== tests/mips_cpu_props.sv ====
`timescale 1ns/1ps

module mips_cpu_props (
  input logic clk,
  input logic reset,
  input logic active,
  input logic data_write,
  input logic data_read
);

  // one memory access kind per instruction
  no_read_and_write: assert property (@(posedge clk) !(data_write && data_read))
    else $error("data_write and data_read high together");

  no_write_when_idle: assert property (@(posedge clk) (reset || !active) |-> !data_write)
    else $error("data_write high during reset or while halted");

  // halted core waits for reset
  halt_holds: assert property (@(posedge clk) (!active && !reset) |=> !active)
    else $error("active rose without a reset");

endmodule

bind mips_cpu_harvard mips_cpu_props u_props (
  .clk        (clk),
  .reset      (reset),
  .active     (active),
  .data_write (data_write),
  .data_read  (data_read)
);

// ==== tests/mips_cpu_tb.sv ====
`timescale 1ns/1ps

module mips_cpu_tb;
  import mips_pkg::*;

  // operation kinds used in the case table
  localparam logic [4:0] k_addu  = 5'd0;
  localparam logic [4:0] k_subu  = 5'd1;
  localparam logic [4:0] k_and   = 5'd2;
  localparam logic [4:0] k_or    = 5'd3;
  localparam logic [4:0] k_xor   = 5'd4;
  localparam logic [4:0] k_slt   = 5'd5;
  localparam logic [4:0] k_sltu  = 5'd6;
  localparam logic [4:0] k_sll   = 5'd7;
  localparam logic [4:0] k_srl   = 5'd8;
  localparam logic [4:0] k_addiu = 5'd9;
  localparam logic [4:0] k_slti  = 5'd10;
  localparam logic [4:0] k_andi  = 5'd11;
  localparam logic [4:0] k_ori   = 5'd12;
  localparam logic [4:0] k_xori  = 5'd13;
  localparam logic [4:0] k_lui   = 5'd14;
  localparam logic [4:0] k_mem   = 5'd15;
  localparam logic [4:0] k_beq   = 5'd16;
  localparam logic [4:0] k_bne   = 5'd17;
  localparam logic [4:0] k_jal   = 5'd18;
  localparam int num_cases = 23;

  typedef struct packed {
    logic [4:0] kind;
    logic       rnd;
    word_t      a;
    word_t      b;
    word_t      v0;
  } case_t;

  // v0 of zero means the reference function supplies it
  case_t cases [num_cases] = '{
    '{k_addu,  1'b1, 32'h0, 32'h0, 32'h0},
    '{k_subu,  1'b1, 32'h0, 32'h0, 32'h0},
    '{k_and,   1'b1, 32'h0, 32'h0, 32'h0},
    '{k_or,    1'b1, 32'h0, 32'h0, 32'h0},
    '{k_xor,   1'b1, 32'h0, 32'h0, 32'h0},
    '{k_slt,   1'b1, 32'h0, 32'h0, 32'h0},
    '{k_sltu,  1'b1, 32'h0, 32'h0, 32'h0},
    '{k_sll,   1'b1, 32'h0, 32'h0, 32'h0},
    '{k_srl,   1'b1, 32'h0, 32'h0, 32'h0},
    '{k_slt,   1'b0, 32'hffff_fff0, 32'h3, 32'h1},
    '{k_addiu, 1'b0, 32'd10, 32'h0000_fffe, 32'd8},
    '{k_slti,  1'b1, 32'h0, 32'h0, 32'h0},
    '{k_andi,  1'b1, 32'h0, 32'h0, 32'h0},
    '{k_ori,   1'b1, 32'h0, 32'h0, 32'h0},
    '{k_xori,  1'b0, 32'h1234_5678, 32'h0000_8000, 32'h1234_d678},
    '{k_lui,   1'b0, 32'h0, 32'h0000_abcd, 32'habcd_0000},
    '{k_mem,   1'b1, 32'h0, 32'h0, 32'h0},
    '{k_mem,   1'b0, 32'hdead_beef, 32'h14, 32'hdead_beef},
    '{k_beq,   1'b0, 32'h55, 32'h55, 32'd1},
    '{k_beq,   1'b0, 32'h1, 32'h2, 32'd2},
    '{k_bne,   1'b0, 32'h7, 32'h7, 32'd2},
    '{k_bne,   1'b1, 32'h0, 32'h0, 32'h0},
    '{k_jal,   1'b0, 32'h0, 32'h0, 32'hbfc0_0018}
  };

  logic        clk = 1'b0;
  logic        reset = 1'b1;
  logic        clk_enable = 1'b0;
  logic        active;
  word_t       register_v0;
  word_t       instr_address;
  word_t       instr_readdata;
  word_t       data_address;
  logic        data_write;
  logic        data_read;
  word_t       data_writedata;
  word_t       data_readdata;
  word_t       imem [64];
  word_t       dmem [16];
  word_t       rng_state = 32'h956b_6db2;
  logic [7:0]  stall_level = 8'd40;
  logic        reported = 1'b0;

  mips_cpu_harvard UUT (
    .clk            (clk),
    .reset          (reset),
    .clk_enable     (clk_enable),
    .active         (active),
    .register_v0    (register_v0),
    .instr_address  (instr_address),
    .instr_readdata (instr_readdata),
    .data_address   (data_address),
    .data_write     (data_write),
    .data_read      (data_read),
    .data_writedata (data_writedata),
    .data_readdata  (data_readdata)
  );

  always #50 clk = ~clk;

  // instruction memory starts at the reset vector and reads zero elsewhere
  assign instr_readdata = (instr_address[31:8] == reset_vector[31:8]) ?
                          imem[instr_address[7:2]] : '0;
  // load data only while the core reads
  assign data_readdata  = data_read ? dmem[data_address[5:2]] : '0;

  always @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 16; i++) begin
        dmem[i] <= {16'hd00d, 10'd0, i[3:0], 2'b00};
      end
    end else if (data_write && clk_enable) begin
      dmem[data_address[5:2]] <= data_writedata;
    end
  end

  function automatic word_t xorshift(input word_t x);
    word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic word_t next_random();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  // enable gaps on pseudo-random cycles
  always @(posedge clk) begin
    word_t r;
    r = next_random();
    clk_enable <= (r[7:0] >= stall_level);
  end

  function automatic word_t encode_itype(input opcode_t op, input reg_addr_t rs,
                                         input reg_addr_t rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t encode_rtype(input funct_t fn, input reg_addr_t rs,
                                         input reg_addr_t rt, input reg_addr_t rd,
                                         input logic [4:0] sh);
    return {op_special, rs, rt, rd, sh, fn};
  endfunction

  // ISA result for v0 after one program of the given kind
  function automatic word_t expected_v0(input logic [4:0] kind, input word_t a, input word_t b);
    word_t sext;
    word_t zext;
    logic  taken;
    sext = {{16{b[15]}}, b[15:0]};
    zext = {16'h0000, b[15:0]};
    taken = (kind == k_beq) ? (a == b) : (a != b);
    case (kind)
      k_addu:  return a + b;
      k_subu:  return a - b;
      k_and:   return a & b;
      k_or:    return a | b;
      k_xor:   return a ^ b;
      k_slt:   return {31'b0, $signed(a) < $signed(b)};
      k_sltu:  return {31'b0, a < b};
      k_sll:   return a << b[4:0];
      k_srl:   return a >> b[4:0];
      k_addiu: return a + sext;
      k_slti:  return {31'b0, $signed(a) < $signed(sext)};
      k_andi:  return a & zext;
      k_ori:   return a | zext;
      k_xori:  return a ^ zext;
      k_lui:   return {b[15:0], 16'h0000};
      k_mem:   return a;
      // delay slot always counts and the second increment only when not taken
      k_beq, k_bne: return taken ? 32'd1 : 32'd2;
      default: return reset_vector + 32'd24;
    endcase
  endfunction

  task automatic load_program(input logic [4:0] kind, input word_t a, input word_t b);
    int          n;
    logic [15:0] offset;
    word_t       target;
    offset = {10'd0, b[5:2], 2'b00};
    target = reset_vector + 32'd28;
    for (int i = 0; i < 64; i++) begin
      imem[i] = '0;
    end
    imem[0] = encode_itype(op_lui, 5'd0, 5'd8, a[31:16]);
    imem[1] = encode_itype(op_ori, 5'd8, 5'd8, a[15:0]);
    imem[2] = encode_itype(op_lui, 5'd0, 5'd9, b[31:16]);
    imem[3] = encode_itype(op_ori, 5'd9, 5'd9, b[15:0]);
    n = 5;
    case (kind)
      k_addu:  imem[4] = encode_rtype(fn_addu, 5'd8, 5'd9, reg_v0, 5'd0);
      k_subu:  imem[4] = encode_rtype(fn_subu, 5'd8, 5'd9, reg_v0, 5'd0);
      k_and:   imem[4] = encode_rtype(fn_and, 5'd8, 5'd9, reg_v0, 5'd0);
      k_or:    imem[4] = encode_rtype(fn_or, 5'd8, 5'd9, reg_v0, 5'd0);
      k_xor:   imem[4] = encode_rtype(fn_xor, 5'd8, 5'd9, reg_v0, 5'd0);
      k_slt:   imem[4] = encode_rtype(fn_slt, 5'd8, 5'd9, reg_v0, 5'd0);
      k_sltu:  imem[4] = encode_rtype(fn_sltu, 5'd8, 5'd9, reg_v0, 5'd0);
      k_sll:   imem[4] = encode_rtype(fn_sll, 5'd0, 5'd8, reg_v0, b[4:0]);
      k_srl:   imem[4] = encode_rtype(fn_srl, 5'd0, 5'd8, reg_v0, b[4:0]);
      k_addiu: imem[4] = encode_itype(op_addiu, 5'd8, reg_v0, b[15:0]);
      k_slti:  imem[4] = encode_itype(op_slti, 5'd8, reg_v0, b[15:0]);
      k_andi:  imem[4] = encode_itype(op_andi, 5'd8, reg_v0, b[15:0]);
      k_ori:   imem[4] = encode_itype(op_ori, 5'd8, reg_v0, b[15:0]);
      k_xori:  imem[4] = encode_itype(op_xori, 5'd8, reg_v0, b[15:0]);
      k_lui:   imem[4] = encode_itype(op_lui, 5'd0, reg_v0, b[15:0]);
      k_mem: begin
        imem[4] = encode_itype(op_sw, 5'd0, 5'd8, offset);
        imem[5] = encode_itype(op_lw, 5'd0, reg_v0, offset);
        n = 6;
      end
      k_beq, k_bne: begin
        // taken branch lands on the jr below
        imem[4] = encode_itype((kind == k_beq) ? op_beq : op_bne, 5'd8, 5'd9, 16'd2);
        imem[5] = encode_itype(op_addiu, reg_v0, reg_v0, 16'd1);
        imem[6] = encode_itype(op_addiu, reg_v0, reg_v0, 16'd1);
        n = 7;
      end
      default: begin
        // ra copy sits in the jal delay slot and the jump skips the increment
        imem[4] = {op_jal, target[27:2]};
        imem[5] = encode_rtype(fn_addu, reg_ra, 5'd0, reg_v0, 5'd0);
        imem[6] = encode_itype(op_addiu, reg_v0, reg_v0, 16'd1);
        n = 7;
      end
    endcase
    // jr r0 ends the program with a nop in its delay slot
    imem[n] = encode_rtype(fn_jr, 5'd0, 5'd0, 5'd0, 5'd0);
  endtask

  task automatic fail_run(input string msg);
    reported = 1'b1;
    $display("%s", msg);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input word_t got, input word_t want);
    if (got !== want) begin
      fail_run($sformatf("Error at %0t ns: %s is %h, expected %h", $time, name, got, want));
    end
  endtask

  task automatic run_program();
    int cycles;
    @(posedge clk);
    reset <= 1'b1;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_value("active", {31'b0, active}, 32'd1);
    check_value("register_v0", register_v0, 32'd0);
    check_value("instr_address", instr_address, reset_vector);
    cycles = 0;
    while (active && cycles < 2000) begin
      @(negedge clk);
      cycles++;
    end
    if (active) begin
      fail_run("Error: the core never halted within 2000 cycles");
    end
  endtask

  initial begin
    case_t c;
    word_t a;
    word_t b;
    word_t want;
    word_t held_v0;
    for (int i = 0; i < num_cases; i++) begin
      c = cases[i];
      a = c.rnd ? next_random() : c.a;
      b = c.rnd ? next_random() : c.b;
      want = (c.v0 != '0) ? c.v0 : expected_v0(c.kind, a, b);
      load_program(c.kind, a, b);
      for (int pass = 0; pass < 2; pass++) begin
        // second pass repeats the entry with long enable gaps
        stall_level = (pass == 0) ? 8'd40 : 8'd190;
        run_program();
        check_value("register_v0", register_v0, want);
        if (c.kind == k_mem) begin
          check_value("dmem", dmem[b[5:2]], a);
        end
        held_v0 = register_v0;
        repeat (20) begin
          @(negedge clk);
          check_value("active", {31'b0, active}, 32'd0);
          check_value("register_v0", register_v0, held_v0);
        end
      end
    end
    reported = 1'b1;
    $display("test passed");
    $finish;
  end

  final begin
    if (!reported) begin
      $display("test failed");
    end
  end

endmodule

// ==== mips_cpu.f ====
hw/mips_pkg.sv
hw/control.sv
hw/register_file.sv
hw/alu.sv
hw/next_pc.sv
hw/mips_cpu_harvard.sv
tests/mips_cpu_props.sv
tests/mips_cpu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= mips_cpu_tb
FILELIST  ?= mips_cpu.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ_DIR)
